// ==== sim.f ====
design/exu_pkg.sv
design/exu_alu.sv
design/exu_csr.sv
design/exu_stage.sv
design/exu_lsu.sv
design/exu_top.sv
testbench/exu_properties.sv
testbench/exu_tb.sv

// ==== Bender.yml ====
package:
  name: exu

sources:
  - files:
      - design/exu_pkg.sv
      - design/exu_alu.sv
      - design/exu_csr.sv
      - design/exu_stage.sv
      - design/exu_lsu.sv
      - design/exu_top.sv
  - target: test
    files:
      - testbench/exu_properties.sv
      - testbench/exu_tb.sv

// ==== testbench/exu_tb.sv ====
`default_nettype none

module exu_tb;
  import exu_pkg::*;

  localparam word_t MTVEC      = 32'h0000_0180;
  localparam int    TOTAL_PKTS = 199;
  localparam int    TIMEOUT    = 20 * TOTAL_PKTS + 100;

  logic        clk;
  logic        rst;
  idu_pkt_t    idu_pkt_i;
  logic        prev_valid_i;
  logic        next_ready_i = 1'b1;
  logic        ready_o;
  logic        valid_o;
  retire_pkt_t retire_o;
  logic        mem_req_o;
  logic        mem_we_o;
  word_t       mem_addr_o;
  word_t       mem_wdata_o;
  logic        mem_ack_i = 1'b0;
  word_t       mem_rdata_i = '0;

  word_t       mem [64];
  word_t       ref_mem [64];
  word_t       csr_model [csr_addr_t];
  retire_pkt_t exp_q [$];
  word_t       pc_ctr = 32'h0000_1000;
  logic        bp_on = 1'b0;
  int          issued = 0;
  int          checks = 0;
  int          errors = 0;
  int          last_checks = 0;
  int          last_errors = 0;
  int          cycles = 0;
  int          total_fails;

  alu_op_e    br_ops [6] = '{ALU_SUB, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU};
  csr_addr_t  csr_list [4] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVEC};
  logic [2:0] f3_list [6] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};

  exu_top #(
    .MTVEC_RESET (MTVEC)
  ) u_exu_top (
    .clk          (clk),
    .rst          (rst),
    .idu_pkt_i    (idu_pkt_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .retire_o     (retire_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ack_i    (mem_ack_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return word_t'($signed(a) < $signed(b));
      ALU_SLTU: return word_t'(a < b);
      ALU_SLE:  return word_t'($signed(a) <= $signed(b));
      ALU_SLEU: return word_t'(a <= b);
      default:  return '0;
    endcase
  endfunction

  // expected retire packet, and the memory and csr side effects
  function automatic retire_pkt_t ref_retire(idu_pkt_t p);
    retire_pkt_t r;
    csr_addr_t   a;
    word_t       addr;
    word_t       res;
    word_t       old;
    a    = p.imm[11:0];
    addr = p.opj + p.imm;
    res  = alu_model(p.alu_op, p.op1, p.op2);
    old  = csr_model.exists(a) ? csr_model[a] : '0;
    r.pc     = p.pc;
    r.inst   = p.inst;
    r.rd     = p.rd;
    r.ebreak = p.ebreak;
    if (p.rd == '0) begin
      r.reg_wdata = '0;
    end else if (p.ren) begin
      r.reg_wdata = ref_mem[addr[7:2]];
    end else if (p.system) begin
      r.reg_wdata = old;
    end else begin
      r.reg_wdata = res;
    end
    r.npc = p.ecall ? csr_model[CSR_MTVEC] : (p.mret ? csr_model[CSR_MEPC] : addr);
    if (p.ben) begin
      r.use_npc = (p.alu_op == ALU_SUB) ? (res == '0) : (res != '0);
    end else begin
      r.use_npc = p.ecall | p.mret | p.jen;
    end
    r.branch_retire = p.system | p.ben | p.ren;
    if (p.wen) begin
      ref_mem[addr[7:2]] = p.op2;
    end
    if (p.ecall) begin
      csr_model[CSR_MEPC]   = p.pc;
      csr_model[CSR_MCAUSE] = 32'd11;
    end else if (p.csr_wen && !p.mret && csr_model.exists(a)) begin
      case (p.inst[14:12])
        F3_CSRRW, F3_CSRRWI: csr_model[a] = p.op1;
        F3_CSRRS, F3_CSRRSI: csr_model[a] = old | p.op1;
        F3_CSRRC, F3_CSRRCI: csr_model[a] = old & ~p.op1;
      endcase
    end
    return r;
  endfunction

  function automatic idu_pkt_t alu_pkt(alu_op_e op);
    idu_pkt_t p;
    p        = '0;
    p.inst   = $urandom;
    p.imm    = $urandom;
    p.opj    = $urandom;
    p.op1    = $urandom;
    p.op2    = $urandom;
    p.alu_op = op;
    p.rd     = 5'($urandom_range(31, 0));
    p.ebreak = 1'($urandom_range(1, 0));
    return p;
  endfunction

  function automatic idu_pkt_t branch_pkt(alu_op_e op);
    idu_pkt_t p;
    p        = alu_pkt(op);
    p.ben    = 1'b1;
    p.ebreak = 1'b0;
    p.rd     = '0;
    // equal operands hit the zero and equal cases
    if ($urandom_range(2, 0) == 0) begin
      p.op2 = p.op1;
    end
    return p;
  endfunction

  function automatic idu_pkt_t mem_pkt(logic load, int idx, word_t data);
    idu_pkt_t p;
    p        = alu_pkt(ALU_ADD);
    p.ebreak = 1'b0;
    p.imm    = word_t'(4 * $urandom_range(15, 0));
    p.opj    = word_t'(4 * idx) - p.imm;
    p.op2    = data;
    p.ren    = load;
    p.wen    = !load;
    if (!load) begin
      p.rd = '0;
    end
    return p;
  endfunction

  function automatic idu_pkt_t csr_pkt(logic [2:0] f3, csr_addr_t a, word_t v, reg_idx_t rd);
    idu_pkt_t p;
    p         = '0;
    p.inst    = {a, v[4:0], f3, rd, 7'b1110011};
    p.imm     = {20'b0, a};
    p.op1     = v;
    p.rd      = rd;
    p.system  = 1'b1;
    p.csr_wen = 1'b1;
    return p;
  endfunction

  task automatic issue(input idu_pkt_t p);
    p.pc = pc_ctr;
    pc_ctr += 4;
    @(negedge clk);
    idu_pkt_i    = p;
    prev_valid_i = 1'b1;
    @(posedge clk);
    while (!ready_o) begin
      @(posedge clk);
    end
    exp_q.push_back(ref_retire(p));
    issued++;
  endtask

  task automatic drain_and_report(input string name);
    @(negedge clk);
    prev_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    $display("%-8s done: %0d checked, %0d errors", name, checks - last_checks,
             errors - last_errors);
    last_checks = checks;
    last_errors = errors;
  endtask

  task automatic check_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail retire_o.%s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic sweep_alu_ops();
    idu_pkt_t p;
    for (int op = 0; op < 12; op++) begin
      for (int n = 0; n < 4; n++) begin
        p = alu_pkt(alu_op_e'(op));
        if (n == 2) begin
          p.op2 = p.op1;
        end
        if (n == 3) begin
          p.rd = '0;
        end
        issue(p);
      end
    end
    drain_and_report("alu");
  endtask

  task automatic branch_and_jump();
    idu_pkt_t p;
    for (int n = 0; n < 24; n++) begin
      if (n % 4 == 3) begin
        p     = alu_pkt(ALU_ADD);
        p.jen = 1'b1;
      end else begin
        p = branch_pkt(br_ops[$urandom_range(5, 0)]);
      end
      issue(p);
    end
    drain_and_report("branch");
  endtask

  task automatic trap_round_trip();
    idu_pkt_t ecall_p;
    idu_pkt_t mret_p;
    ecall_p        = '0;
    ecall_p.system = 1'b1;
    ecall_p.ecall  = 1'b1;
    ecall_p.inst   = 32'h0000_0073;
    mret_p         = '0;
    mret_p.system  = 1'b1;
    mret_p.mret    = 1'b1;
    mret_p.inst    = 32'h3020_0073;
    issue(ecall_p);
    issue(csr_pkt(F3_CSRRS, CSR_MEPC, '0, 5'd1));
    issue(csr_pkt(F3_CSRRS, CSR_MCAUSE, '0, 5'd2));
    issue(mret_p);
    // move the trap vector and trap once more
    issue(csr_pkt(F3_CSRRW, CSR_MTVEC, 32'h0000_0400, 5'd3));
    issue(ecall_p);
    issue(mret_p);
    drain_and_report("trap");
  endtask

  task automatic csr_read_modify();
    word_t v;
    foreach (csr_list[c]) begin
      foreach (f3_list[f]) begin
        v = f3_list[f][2] ? word_t'($urandom_range(31, 0)) : word_t'($urandom);
        issue(csr_pkt(f3_list[f], csr_list[c], v, 5'($urandom_range(31, 1))));
        issue(csr_pkt(F3_CSRRS, csr_list[c], '0, 5'($urandom_range(31, 1))));
      end
    end
    drain_and_report("csr");
  endtask

  task automatic store_load_pairs();
    int idx;
    for (int n = 0; n < 16; n++) begin
      idx = $urandom_range(63, 0);
      issue(mem_pkt(1'b0, idx, $urandom));
      if ($urandom_range(1, 0) == 0) begin
        idx = $urandom_range(63, 0);
      end
      issue(mem_pkt(1'b1, idx, '0));
    end
    drain_and_report("memory");
  endtask

  task automatic random_mix();
    for (int n = 0; n < 40; n++) begin
      case ($urandom_range(3, 0))
        0:       issue(alu_pkt(alu_op_e'($urandom_range(11, 0))));
        1:       issue(branch_pkt(br_ops[$urandom_range(5, 0)]));
        2:       issue(mem_pkt(1'b0, $urandom_range(63, 0), $urandom));
        default: issue(mem_pkt(1'b1, $urandom_range(63, 0), '0));
      endcase
    end
    drain_and_report("mix");
  endtask

  // retire stalls about a quarter of the time
  always @(negedge clk) begin
    if (bp_on && $urandom_range(3, 0) == 0) begin
      next_ready_i = 1'b0;
    end else begin
      next_ready_i = 1'b1;
    end
  end

  always @(negedge clk) begin : memory_model
    logic       pending;
    int         wait_cnt;
    logic [5:0] req_idx;
    logic       req_we;
    word_t      req_wdata;
    mem_ack_i = 1'b0;
    if (rst) begin
      pending = 1'b0;
    end else begin
      if (pending) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          pending   = 1'b0;
          mem_ack_i = 1'b1;
          if (req_we) begin
            mem[req_idx] = req_wdata;
            mem_rdata_i  = $urandom;
          end else begin
            mem_rdata_i = mem[req_idx];
          end
        end
      end
      if (mem_req_o) begin
        pending   = 1'b1;
        wait_cnt  = $urandom_range(4, 1);
        req_idx   = mem_addr_o[7:2];
        req_we    = mem_we_o;
        req_wdata = mem_wdata_o;
      end
    end
  end

  always @(posedge clk) begin : compare_retire
    retire_pkt_t exp;
    if (!rst && valid_o && next_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("retire of pc %h with no instruction outstanding", retire_o.pc);
        errors++;
      end else begin
        exp = exp_q.pop_front();
        check_field("pc", retire_o.pc, exp.pc);
        check_field("inst", retire_o.inst, exp.inst);
        check_field("rd", word_t'(retire_o.rd), word_t'(exp.rd));
        check_field("reg_wdata", retire_o.reg_wdata, exp.reg_wdata);
        check_field("npc", retire_o.npc, exp.npc);
        check_field("use_npc", word_t'(retire_o.use_npc), word_t'(exp.use_npc));
        check_field("branch_retire", word_t'(retire_o.branch_retire),
                    word_t'(exp.branch_retire));
        check_field("ebreak", word_t'(retire_o.ebreak), word_t'(exp.ebreak));
        checks++;
      end
    end
  end

  initial begin : watchdog
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d retires still expected", cycles, exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(77));
    rst          = 1'b1;
    prev_valid_i = 1'b0;
    idu_pkt_i    = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 32'hc0de_0000 + word_t'(i) * 32'h0001_0101;
      ref_mem[i] = 32'hc0de_0000 + word_t'(i) * 32'h0001_0101;
    end
    csr_model[CSR_MSCRATCH] = '0;
    csr_model[CSR_MEPC]     = '0;
    csr_model[CSR_MCAUSE]   = '0;
    csr_model[CSR_MTVEC]    = MTVEC;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst   = 1'b0;
    bp_on = 1'b1;
    sweep_alu_ops();
    branch_and_jump();
    trap_round_trip();
    csr_read_modify();
    store_load_pairs();
    random_mix();
    total_fails = errors + u_exu_top.u_props.fail_count;
    $display("issued %0d, checked %0d, errors %0d, assertion failures %0d", issued, checks,
             errors, u_exu_top.u_props.fail_count);
    if (total_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/exu_properties.sv ====
`default_nettype none

module exu_properties (
  input wire                       clk,
  input wire                       rst,
  input wire                       ready_i,
  input wire                       valid_i,
  input wire                       next_ready_i,
  input wire                       mem_req_i,
  input wire                       mem_ack_i,
  input wire exu_pkg::retire_pkt_t retire_i
);
  int unsigned fail_count = 0;
  logic        mem_busy_q;

  // open from the request pulse until the acknowledge
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_busy_q <= 1'b0;
    end else if (mem_req_i) begin
      mem_busy_q <= 1'b1;
    end else if (mem_ack_i) begin
      mem_busy_q <= 1'b0;
    end
  end

  // stage must stall while memory still owes an answer
  no_accept_during_access: assert property (@(posedge clk) disable iff (rst)
    (mem_req_i || mem_busy_q) |-> !ready_i)
    else begin
      fail_count++;
      $error("ready_o high while a memory access is outstanding");
    end

  mem_req_single_cycle: assert property (@(posedge clk) disable iff (rst)
    mem_req_i |=> !mem_req_i)
    else begin
      fail_count++;
      $error("mem_req_o held for more than one cycle");
    end

  retire_held_on_stall: assert property (@(posedge clk) disable iff (rst)
    valid_i && !next_ready_i |=> $stable(retire_i))
    else begin
      fail_count++;
      $error("retire_o changed while stalled");
    end

  no_valid_in_reset: assert property (@(posedge clk)
    rst |=> !valid_i)
    else begin
      fail_count++;
      $error("valid_o high during reset");
    end

endmodule

bind exu_top exu_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .ready_i      (ready_o),
  .valid_i      (valid_o),
  .next_ready_i (next_ready_i),
  .mem_req_i    (mem_req_o),
  .mem_ack_i    (mem_ack_i),
  .retire_i     (retire_o)
);

`default_nettype wire

// ==== design/exu_top.sv ====
`default_nettype none

module exu_top #(
  parameter exu_pkg::word_t MTVEC_RESET = 32'h0000_0100
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire exu_pkg::idu_pkt_t idu_pkt_i,
  input  wire                    prev_valid_i,
  input  wire                    next_ready_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output exu_pkg::retire_pkt_t   retire_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output exu_pkg::word_t         mem_addr_o,
  output exu_pkg::word_t         mem_wdata_o,
  input  wire                    mem_ack_i,
  input  wire exu_pkg::word_t    mem_rdata_i
);
  import exu_pkg::*;

  lsu_req_t lsu_req;
  logic     lsu_avalid;
  logic     lsu_done;
  word_t    lsu_rdata;

  exu_stage #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_stage (
    .clk          (clk),
    .rst          (rst),
    .idu_pkt_i    (idu_pkt_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .retire_o     (retire_o),
    .lsu_req_o    (lsu_req),
    .lsu_avalid_o (lsu_avalid),
    .lsu_done_i   (lsu_done),
    .lsu_rdata_i  (lsu_rdata)
  );

  exu_lsu u_lsu (
    .clk         (clk),
    .rst         (rst),
    .req_i       (lsu_req),
    .avalid_i    (lsu_avalid),
    .done_o      (lsu_done),
    .rdata_o     (lsu_rdata),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// ==== design/exu_lsu.sv ====
`default_nettype none

module exu_lsu (
  input  wire                    clk,
  input  wire                    rst,
  input  wire exu_pkg::lsu_req_t req_i,
  input  wire                    avalid_i,
  output logic                   done_o,
  output exu_pkg::word_t         rdata_o,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output exu_pkg::word_t         mem_addr_o,
  output exu_pkg::word_t         mem_wdata_o,
  input  wire                    mem_ack_i,
  input  wire exu_pkg::word_t    mem_rdata_i
);
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    DONE
  } lsu_state_e;

  lsu_state_e state_q;
  logic       start;
  logic       ack;

  assign start = (state_q == IDLE) & avalid_i & (req_i.ren | req_i.wen);
  assign ack   = (state_q == WAIT_ACK) & mem_ack_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      mem_req_o <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      mem_req_o <= start;
      done_o    <= ack;
      case (state_q)
        IDLE:     if (start) state_q <= WAIT_ACK;
        WAIT_ACK: if (mem_ack_i) state_q <= DONE;
        // hold until the stage drops its access level
        DONE:     if (!avalid_i) state_q <= IDLE;
        default:  state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr_o  <= req_i.addr;
      mem_wdata_o <= req_i.wdata;
      mem_we_o    <= req_i.wen;
    end
    if (ack) begin
      rdata_o <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/exu_stage.sv ====
`default_nettype none

module exu_stage #(
  parameter exu_pkg::word_t MTVEC_RESET = 32'h0000_0100
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire exu_pkg::idu_pkt_t idu_pkt_i,
  input  wire                    prev_valid_i,
  input  wire                    next_ready_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output exu_pkg::retire_pkt_t   retire_o,
  output exu_pkg::lsu_req_t      lsu_req_o,
  output logic                   lsu_avalid_o,
  input  wire                    lsu_done_i,
  input  wire exu_pkg::word_t    lsu_rdata_i
);
  import exu_pkg::*;

  idu_pkt_t   pkt_q;
  word_t      load_data_q;
  word_t      csr_old_q;
  logic       ready_q;
  logic       alu_valid_q;
  logic       lsu_valid_q;
  logic       avalid_q;
  logic       committed_q;

  word_t      alu_res;
  word_t      addr;
  word_t      csr_rdata;
  word_t      csr_wdata;
  word_t      mepc;
  word_t      mtvec;
  logic [2:0] funct3;
  logic       accept;
  logic       is_mem;
  logic       commit;
  logic       taken;

  assign ready_o = ready_q & next_ready_i;
  assign accept  = prev_valid_i & ready_o;
  assign is_mem  = pkt_q.ren | pkt_q.wen;
  assign valid_o = is_mem ? lsu_valid_q : alu_valid_q;
  // first valid cycle of each instruction
  assign commit  = valid_o & ~committed_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q     <= 1'b1;
      alu_valid_q <= 1'b0;
      lsu_valid_q <= 1'b0;
      avalid_q    <= 1'b0;
      committed_q <= 1'b0;
    end else begin
      if (next_ready_i) begin
        lsu_valid_q <= 1'b0;
      end
      if (accept) begin
        alu_valid_q <= 1'b1;
      end else if (next_ready_i) begin
        alu_valid_q <= 1'b0;
      end
      if (commit) begin
        committed_q <= 1'b1;
      end
      if (accept) begin
        committed_q <= 1'b0;
        // loads and stores hold the stage until done
        if (idu_pkt_i.ren | idu_pkt_i.wen) begin
          avalid_q <= 1'b1;
          ready_q  <= 1'b0;
        end
      end
      if (lsu_done_i) begin
        lsu_valid_q <= 1'b1;
        avalid_q    <= 1'b0;
        ready_q     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= idu_pkt_i;
    end
    if (lsu_done_i) begin
      load_data_q <= lsu_rdata_i;
    end
    if (commit) begin
      csr_old_q <= csr_rdata;
    end
  end

  assign addr   = pkt_q.opj + pkt_q.imm;
  assign funct3 = pkt_q.inst[14:12];

  assign lsu_req_o.addr  = addr;
  assign lsu_req_o.wdata = pkt_q.op2;
  assign lsu_req_o.ren   = pkt_q.ren;
  assign lsu_req_o.wen   = pkt_q.wen;
  assign lsu_avalid_o    = avalid_q;

  exu_alu u_alu (
    .a_i   (pkt_q.op1),
    .b_i   (pkt_q.op2),
    .op_i  (pkt_q.alu_op),
    .res_o (alu_res)
  );

  exu_csr #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr (
    .clk      (clk),
    .rst      (rst),
    .wen_i    (pkt_q.csr_wen),
    .commit_i (commit),
    .ecall_i  (pkt_q.ecall),
    .mret_i   (pkt_q.mret),
    .addr_i   (pkt_q.imm[11:0]),
    .wdata_i  (csr_wdata),
    .pc_i     (pkt_q.pc),
    .rdata_o  (csr_rdata),
    .mepc_o   (mepc),
    .mtvec_o  (mtvec)
  );

  // immediate forms arrive with zimm already in op1
  always_comb begin
    case (funct3)
      F3_CSRRW, F3_CSRRWI: csr_wdata = pkt_q.op1;
      F3_CSRRS, F3_CSRRSI: csr_wdata = csr_rdata | pkt_q.op1;
      F3_CSRRC, F3_CSRRCI: csr_wdata = csr_rdata & ~pkt_q.op1;
      default:             csr_wdata = '0;
    endcase
  end

  always_comb begin
    if (pkt_q.ben) begin
      case (pkt_q.alu_op)
        ALU_SUB: taken = alu_res == '0;
        ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLE, ALU_SLEU: taken = alu_res != '0;
        default: taken = 1'b0;
      endcase
    end else begin
      taken = pkt_q.ecall | pkt_q.mret | pkt_q.jen;
    end
  end

  always_comb begin
    retire_o.pc   = pkt_q.pc;
    retire_o.inst = pkt_q.inst;
    retire_o.rd   = pkt_q.rd;
    if (pkt_q.rd == '0) begin
      retire_o.reg_wdata = '0;
    end else if (pkt_q.ren) begin
      retire_o.reg_wdata = load_data_q;
    end else if (pkt_q.system) begin
      // csr already holds the new value after the commit cycle
      retire_o.reg_wdata = committed_q ? csr_old_q : csr_rdata;
    end else begin
      retire_o.reg_wdata = alu_res;
    end
    if (pkt_q.ecall) begin
      retire_o.npc = mtvec;
    end else if (pkt_q.mret) begin
      retire_o.npc = mepc;
    end else begin
      retire_o.npc = addr;
    end
    retire_o.use_npc       = taken;
    retire_o.branch_retire = pkt_q.system | pkt_q.ben | pkt_q.ren;
    retire_o.ebreak        = pkt_q.ebreak;
  end

endmodule

`default_nettype wire

// ==== design/exu_csr.sv ====
`default_nettype none

module exu_csr #(
  parameter exu_pkg::word_t MTVEC_RESET = 32'h0000_0100
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     wen_i,
  input  wire                     commit_i,
  input  wire                     ecall_i,
  input  wire                     mret_i,
  input  wire exu_pkg::csr_addr_t addr_i,
  input  wire exu_pkg::word_t     wdata_i,
  input  wire exu_pkg::word_t     pc_i,
  output exu_pkg::word_t          rdata_o,
  output exu_pkg::word_t          mepc_o,
  output exu_pkg::word_t          mtvec_o
);
  import exu_pkg::*;

  word_t mepc_q;
  word_t mtvec_q;
  word_t mcause_q;
  word_t mscratch_q;
  logic  trap;
  logic  csr_write;

  // trap entry and return take priority over a csr write
  assign trap      = ecall_i | mret_i;
  assign csr_write = commit_i & wen_i & ~trap;

  always_comb begin
    case (addr_i)
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MCAUSE:   rdata_o = mcause_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      default:      rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q     <= '0;
      mtvec_q    <= MTVEC_RESET;
      mcause_q   <= '0;
      mscratch_q <= '0;
    end else if (commit_i & ecall_i) begin
      mepc_q   <= pc_i;
      mcause_q <= CAUSE_ECALL_M;
    end else if (csr_write) begin
      case (addr_i)
        CSR_MEPC:     mepc_q     <= wdata_i;
        CSR_MTVEC:    mtvec_q    <= wdata_i;
        CSR_MCAUSE:   mcause_q   <= wdata_i;
        CSR_MSCRATCH: mscratch_q <= wdata_i;
        default: begin
        end
      endcase
    end
  end

  // mret only needs mepc, which the stage picks up as npc
  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

endmodule

`default_nettype wire

// ==== design/exu_alu.sv ====
`default_nettype none

module exu_alu (
  input  wire exu_pkg::word_t   a_i,
  input  wire exu_pkg::word_t   b_i,
  input  wire exu_pkg::alu_op_e op_i,
  output exu_pkg::word_t        res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;
  logic       eq;

  assign shamt = b_i[4:0];
  assign lt    = $signed(a_i) < $signed(b_i);
  assign ltu   = a_i < b_i;
  assign eq    = a_i == b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      // compares give 0 or 1
      ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, lt};
      ALU_SLTU: res_o = {{(XLEN-1){1'b0}}, ltu};
      ALU_SLE:  res_o = {{(XLEN-1){1'b0}}, lt | eq};
      ALU_SLEU: res_o = {{(XLEN-1){1'b0}}, ltu | eq};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLE,
    ALU_SLEU
  } alu_op_e;

  // funct3 of the zicsr instructions
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11;

  typedef struct packed {
    word_t    pc;
    inst_t    inst;
    word_t    imm;
    word_t    op1;
    word_t    op2;
    word_t    opj;
    alu_op_e  alu_op;
    reg_idx_t rd;
    logic     ren;
    logic     wen;
    logic     jen;
    logic     ben;
    logic     system;
    logic     csr_wen;
    logic     ebreak;
    logic     ecall;
    logic     mret;
  } idu_pkt_t;

  typedef struct packed {
    word_t    pc;
    inst_t    inst;
    reg_idx_t rd;
    word_t    reg_wdata;
    word_t    npc;
    logic     use_npc;
    logic     branch_retire;
    logic     ebreak;
  } retire_pkt_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  ren;
    logic  wen;
  } lsu_req_t;

endpackage

`default_nettype wire
